//--- build.f
logic/cw_route_pkg.sv
logic/cw_reg_bank.sv
logic/trig_select.sv
logic/target_io_route.sv
logic/target_power.sv
logic/cw_route_top.sv
bench/cw_route_tb.sv

//--- bench/cw_route_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cw_route_tb
   import cw_route_pkg::*;
();

   localparam int CLK_PERIOD  = 4;
   localparam int STIM_CYCLES = 1200;            // rough length of the stimulus below
   localparam int RAMP_LIMIT  = 2**(4+3) + 4;    // pwm and step bits plus a small margin
   localparam int PWROFF_BIT  = IOR_EXTRA*8 + EXTRA_PWROFF;
   localparam int FAST_BIT    = IOR_EXTRA*8 + EXTRA_FAST;

   logic       clk_usb;
   logic       reset;
   reg_addr_t  reg_address;
   logic [6:0] reg_bytecnt;
   reg_byte_t  reg_datai;
   logic       reg_read;
   logic       reg_write;
   logic [4:0] trig_ext_in;        // nrst, io1..io4
   logic [3:0] trig_mod_in;        // advio, sad, decoded, trace
   logic       uart_tx;
   logic [NUM_GPIO-1:0] tgt_en;    // target model drive enables
   logic [NUM_GPIO-1:0] tgt_val;
   wire reg_byte_t      reg_datao;
   wire                 trigger_ext;
   wire                 trigger;
   wire                 uart_rx;
   wire                 power_off;
   wire                 enable_avrprog;
   wire [5:0]           extgpio;   // nrst, pdid, pdic as enable/level pairs
   wire [NUM_GPIO-1:0]  pin_w;

   // shadow copies of what the host wrote
   reg_byte_t  sh_trigsrc;
   reg_byte_t  sh_trigmod;
   ioroute_t   sh_ioroute;
   logic       sh_highz;           // power-off level one edge after the register
   logic [NUM_GPIO-1:0] pins_prev;
   logic       ramp_on;            // soft-start window with the power check suspended
   int         ramp_cnt;
   logic       saw_hi;
   logic       saw_lo;

   reg_byte_t  rd_exp;
   logic       ext_exp;
   logic       trig_exp;
   logic       rx_exp;
   logic [NUM_GPIO-1:0] pin_exp;
   logic [NUM_GPIO-1:0] float_cfg; // dut never drives this pin in the current setup
   integer     seed = 92;
   int         errors = 0;

   cw_route_top #(.P_PWM_BITS(4), .P_PWM_ON(10), .P_STEP_BITS(3)) dut0 (
      .clk_usb (clk_usb), .reset (reset),
      .reg_address_i (reg_address), .reg_bytecnt_i (reg_bytecnt), .reg_datai_i (reg_datai),
      .reg_read_i (reg_read), .reg_write_i (reg_write), .reg_datao_o (reg_datao),
      .trig_nrst_i (trig_ext_in[0]), .trig_io1_i (trig_ext_in[1]), .trig_io2_i (trig_ext_in[2]),
      .trig_io3_i (trig_ext_in[3]), .trig_io4_i (trig_ext_in[4]),
      .trig_advio_i (trig_mod_in[0]), .trig_sad_i (trig_mod_in[1]),
      .trig_decoded_i (trig_mod_in[2]), .trig_trace_i (trig_mod_in[3]),
      .trigger_ext_o (trigger_ext), .trigger_o (trigger),
      .targetio1_io (pin_w[0]), .targetio2_io (pin_w[1]),
      .targetio3_io (pin_w[2]), .targetio4_io (pin_w[3]),
      .uart_tx_i (uart_tx), .uart_rx_o (uart_rx), .power_off_o (power_off),
      .enable_avrprog_o (enable_avrprog),
      .enable_output_nrst_o (extgpio[0]), .output_nrst_o (extgpio[1]),
      .enable_output_pdid_o (extgpio[2]), .output_pdid_o (extgpio[3]),
      .enable_output_pdic_o (extgpio[4]), .output_pdic_o (extgpio[5])
   );

   // a released target line is pulled high
   for (genvar g = 0; g < NUM_GPIO; g++) begin : g_target
      pullup pu (pin_w[g]);
      assign pin_w[g] = tgt_en[g] ? tgt_val[g] : 1'bz;
   end

   always #(CLK_PERIOD/2) clk_usb = ~clk_usb;

   always @(posedge clk_usb) begin
      if (reset) begin
         sh_trigsrc <= 8'h20;
         sh_trigmod <= '0;
         sh_ioroute <= 64'h0201;   // gpio1 tx, gpio2 rx
         sh_highz   <= 1'b0;
         pins_prev  <= '0;
         ramp_on    <= 1'b0;
         ramp_cnt   <= 0;
         saw_hi     <= 1'b0;
         saw_lo     <= 1'b0;
      end else begin
         if (reg_write) begin
            case (reg_address)
               CW_TRIGSRC_ADDR: sh_trigsrc <= reg_datai;
               CW_TRIGMOD_ADDR: sh_trigmod <= reg_datai;
               CW_IOROUTE_ADDR: begin
                  if (reg_bytecnt < IOR_BYTES) begin
                     sh_ioroute[reg_bytecnt[2:0]*8 +: 8] <= reg_datai;
                  end
               end
               default: ;
            endcase
         end
         sh_highz  <= sh_ioroute[PWROFF_BIT];
         pins_prev <= pin_exp;
         if (sh_ioroute[PWROFF_BIT]) begin
            ramp_on <= 1'b0;                      // off cancels a running ramp
         end else if (sh_highz && !sh_ioroute[FAST_BIT]) begin
            ramp_on  <= 1'b1;                     // slow power-up starts here
            ramp_cnt <= 0;
            saw_hi   <= 1'b0;
            saw_lo   <= 1'b0;
         end else if (ramp_on) begin
            ramp_cnt <= ramp_cnt + 1;
            saw_hi   <= saw_hi | power_off;
            saw_lo   <= saw_lo | !power_off;
            if (ramp_cnt == RAMP_LIMIT-1) ramp_on <= 1'b0;
         end
      end
   end

   // readback and trigger rules
   always_comb begin
      logic any_hi;
      logic all_hi;
      rd_exp = '0;
      case (reg_address)
         CW_TRIGSRC_ADDR: rd_exp = sh_trigsrc;
         CW_TRIGMOD_ADDR: rd_exp = sh_trigmod;
         CW_IOROUTE_ADDR: begin
            if (reg_bytecnt < IOR_BYTES) rd_exp = sh_ioroute[reg_bytecnt[2:0]*8 +: 8];
         end
         CW_IOREAD_ADDR:  rd_exp = {4'h0, pins_prev};
         default:         rd_exp = '0;
      endcase
      any_hi = 1'b0;
      all_hi = 1'b1;
      for (int i = 0; i < 5; i++) begin
         if (sh_trigsrc[TRIGSRC_NRST + i]) begin
            any_hi = any_hi | trig_ext_in[i];
            all_hi = all_hi & trig_ext_in[i];
         end
      end
      case (sh_trigsrc[7:6])
         2'd0:    ext_exp = any_hi;
         2'd1:    ext_exp = all_hi;
         2'd2:    ext_exp = !all_hi;
         default: ext_exp = 1'b0;
      endcase
      case (sh_trigmod[2:0])
         TRIG_EXT:     trig_exp = ext_exp;
         TRIG_ADVIO:   trig_exp = trig_mod_in[0];
         TRIG_SAD:     trig_exp = trig_mod_in[1];
         TRIG_DECODED: trig_exp = trig_mod_in[2];
         TRIG_TRACE:   trig_exp = trig_mod_in[3];
         default:      trig_exp = 1'b0;
      endcase
   end

   // pin levels seen through the pullup and the uart rx they give
   always_comb begin
      reg_byte_t cfg;
      logic      drv;
      logic      lvl;
      logic      found;
      for (int g = 0; g < NUM_GPIO; g++) begin
         cfg          = sh_ioroute[g*8 +: 8];
         drv          = 1'b1;
         lvl          = 1'b0;
         float_cfg[g] = 1'b0;
         if (sh_highz || !(cfg[GPIO_TX] || cfg[GPIO_EN] ||
                           (g == 2 && (cfg[GPIO_OC] || cfg[GPIO_OCTX]))))
            float_cfg[g] = 1'b1;
         if (float_cfg[g]) drv = 1'b0;
         else if (cfg[GPIO_TX]) lvl = uart_tx;
         else if (g == 2 && cfg[GPIO_OC]) lvl = 1'b0;
         else if (g == 2 && cfg[GPIO_OCTX]) drv = !uart_tx;   // low or released
         else lvl = cfg[GPIO_LVL];
         pin_exp[g] = drv ? lvl : (tgt_en[g] ? tgt_val[g] : 1'b1);
      end
      rx_exp = 1'b1;
      found  = 1'b0;
      for (int g = 0; g < NUM_GPIO; g++) begin
         if (!found && sh_ioroute[g*8 + GPIO_RX]) begin
            rx_exp = pin_exp[g];
            found  = 1'b1;
         end
      end
   end

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      errors = errors + 1;
      $display("Fail %0t %s got %0h exp %0h", $time, name, got, exp);
   endtask

   task automatic flag_failure(input string what);
      errors = errors + 1;
      $display("%0t %s", $time, what);
   endtask

   a_read_value: assert property (@(posedge clk_usb) disable iff (reset)
      reg_read |-> reg_datao == rd_exp)
      else report_mismatch("reg_datao_o", $sampled(reg_datao), $sampled(rd_exp));
   a_read_idle: assert property (@(posedge clk_usb) disable iff (reset)
      !reg_read |-> reg_datao == '0)
      else report_mismatch("reg_datao_o (idle)", $sampled(reg_datao), 0);
   a_trig_ext: assert property (@(posedge clk_usb) disable iff (reset) trigger_ext == ext_exp)
      else report_mismatch("trigger_ext_o", $sampled(trigger_ext), $sampled(ext_exp));
   a_trig_out: assert property (@(posedge clk_usb) disable iff (reset) trigger == trig_exp)
      else report_mismatch("trigger_o", $sampled(trigger), $sampled(trig_exp));
   a_pins: assert property (@(posedge clk_usb) disable iff (reset) pin_w == pin_exp)
      else report_mismatch("targetio4..1", $sampled(pin_w), $sampled(pin_exp));
   a_uart_rx: assert property (@(posedge clk_usb) disable iff (reset) uart_rx == rx_exp)
      else report_mismatch("uart_rx_o", $sampled(uart_rx), $sampled(rx_exp));
   a_extra: assert property (@(posedge clk_usb) disable iff (reset)
      {enable_avrprog, extgpio} == {sh_ioroute[IOR_EXTRA*8], sh_ioroute[IOR_EXTGPIO*8 +: 6]})
      else report_mismatch("avrprog/extra gpio outputs", $sampled({enable_avrprog, extgpio}),
                           $sampled({sh_ioroute[IOR_EXTRA*8], sh_ioroute[IOR_EXTGPIO*8 +: 6]}));
   a_power: assert property (@(posedge clk_usb) disable iff (reset)
      !ramp_on |-> power_off == sh_highz)
      else report_mismatch("power_off_o", $sampled(power_off), $sampled(sh_highz));
   a_ramp_pulses: assert property (@(posedge clk_usb) disable iff (reset)
      (ramp_on && ramp_cnt == RAMP_LIMIT-1) |-> (saw_hi && saw_lo))
      else flag_failure("soft-start ramp ended without pwm pulses on power_off_o");

   // one cycle with new random levels on the free inputs at the falling edge
   task automatic tick();
      @(negedge clk_usb);
      trig_ext_in = 5'($random(seed));
      trig_mod_in = 4'($random(seed));
      uart_tx     = 1'($random(seed));
      tgt_val     = 4'($random(seed));
      tgt_en      = 4'($random(seed)) & float_cfg;   // target only drives released lines
   endtask

   task automatic idle(input int n);
      repeat (n) tick();
   endtask

   task automatic write_reg(input reg_addr_t addr, input logic [6:0] cnt, input reg_byte_t data);
      reg_address = addr;
      reg_bytecnt = cnt;
      reg_datai   = data;
      reg_write   = 1'b1;
      tick();
      reg_write   = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr, input logic [6:0] cnt);
      reg_address = addr;
      reg_bytecnt = cnt;
      reg_read    = 1'b1;
      tick();
      reg_read    = 1'b0;
   endtask

   task automatic set_gpios(input logic [31:0] cfg);   // gpio4..gpio1 routing bytes
      for (int g = 0; g < NUM_GPIO; g++) write_reg(CW_IOROUTE_ADDR, g, cfg[g*8 +: 8]);
   endtask

   initial begin
      int        r;
      reg_addr_t addr;
      reg_byte_t data;
      clk_usb     = 1'b0;
      reset       = 1'b1;
      reg_address = '0;
      reg_bytecnt = '0;
      reg_datai   = '0;
      reg_read    = 1'b0;
      reg_write   = 1'b0;
      trig_ext_in = '0;
      trig_mod_in = '0;
      uart_tx     = 1'b1;
      tgt_en      = '0;
      tgt_val     = '0;
      repeat (5) @(negedge clk_usb);
      reset = 1'b0;

      read_reg(CW_TRIGSRC_ADDR, 0);   // reset values
      read_reg(CW_TRIGMOD_ADDR, 0);
      for (int b = 0; b < IOR_BYTES; b++) read_reg(CW_IOROUTE_ADDR, b);
      read_reg(CW_IOREAD_ADDR, 0);

      for (int n = 0; n < 60; n++) begin
         r    = $unsigned($random(seed)) % 10;
         data = $random(seed);
         addr = (r == 0) ? CW_TRIGSRC_ADDR : (r == 1) ? CW_TRIGMOD_ADDR : CW_IOROUTE_ADDR;
         write_reg(addr, (r < 2) ? 0 : r - 2, data);
         read_reg(addr, (r < 2) ? 0 : r - 2);
      end

      // unmapped addresses and byte counts past the routing register
      for (int n = 0; n < 20; n++) begin
         addr = $random(seed);
         if (addr inside {CW_TRIGSRC_ADDR, CW_TRIGMOD_ADDR, CW_IOROUTE_ADDR, CW_IOREAD_ADDR})
            addr = 8'hff;
         write_reg(addr, 0, $random(seed));
         read_reg(addr, 0);
         r = 8 + $unsigned($random(seed)) % 120;
         write_reg(CW_IOROUTE_ADDR, r, $random(seed));
         read_reg(CW_IOROUTE_ADDR, r);
      end

      for (int m = 0; m < 4; m++) begin
         for (int c = 0; c < 8; c++) begin
            data      = $random(seed);
            data[7:6] = m[1:0];
            if (c == 7) data[5:1] = '0;   // nothing enabled
            write_reg(CW_TRIGSRC_ADDR, 0, data);
            data      = $random(seed);
            data[2:0] = c[2:0];
            write_reg(CW_TRIGMOD_ADDR, 0, data);
            idle(6);
         end
      end

      write_reg(CW_IOROUTE_ADDR, IOR_EXTRA, 8'h04);   // fast power on
      idle(3);
      set_gpios(32'h8010_c001);   // tx, level 1, drive low, level 0
      idle(12);
      set_gpios(32'h0220_01c2);   // open collector tx on gpio3
      idle(12);
      set_gpios(32'h4011_1030);   // oc bits are ignored off gpio3 and tx beats oc
      idle(12);
      set_gpios(32'he030_0003);   // oc beats octx while tx loops into rx
      idle(12);

      for (int k = 0; k < 16; k++) begin
         for (int g = 0; g < NUM_GPIO; g++)
            write_reg(CW_IOROUTE_ADDR, g, k[g] ? 8'h02 : 8'h00);
         idle(4);
         read_reg(CW_IOREAD_ADDR, 0);
      end

      write_reg(CW_IOROUTE_ADDR, IOR_EXTRA, 8'h05);   // avr programming on
      for (int n = 0; n < 8; n++) begin
         write_reg(CW_IOROUTE_ADDR, IOR_EXTGPIO, $random(seed));
         idle(2);
      end

      set_gpios(32'h8010_c001);
      write_reg(CW_IOROUTE_ADDR, IOR_EXTRA, 8'h02);   // power off releases all pads
      idle(6);
      write_reg(CW_IOROUTE_ADDR, IOR_EXTRA, 8'h06);
      idle(2);
      write_reg(CW_IOROUTE_ADDR, IOR_EXTRA, 8'h04);   // fast power on
      idle(6);
      write_reg(CW_IOROUTE_ADDR, IOR_EXTRA, 8'h02);
      idle(4);
      write_reg(CW_IOROUTE_ADDR, IOR_EXTRA, 8'h00);   // soft start
      idle(RAMP_LIMIT + 8);
      write_reg(CW_IOROUTE_ADDR, IOR_EXTRA, 8'h02);
      idle(4);
      write_reg(CW_IOROUTE_ADDR, IOR_EXTRA, 8'h00);
      idle(30);
      write_reg(CW_IOROUTE_ADDR, IOR_EXTRA, 8'h02);   // off in the middle of the ramp
      idle(6);
      write_reg(CW_IOROUTE_ADDR, IOR_EXTRA, 8'h00);
      idle(RAMP_LIMIT + 8);
      idle(4);

      $display("checks done, %0d errors", errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(2 * (STIM_CYCLES + 2**(4+3)) * CLK_PERIOD);
      $display("watchdog expired, stimulus did not finish in time");
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/cw_route_top.sv
`timescale 1ns/100ps
`default_nettype none

module cw_route_top
   import cw_route_pkg::*;
#(
   parameter int P_BYTECNT_BITS = 7,
   parameter int P_PWM_BITS     = 11,
   parameter int P_PWM_ON       = 1400,
   parameter int P_STEP_BITS    = 14
) (
   input  wire                      clk_usb,
   input  wire                      reset,
   // host bus
   input  wire reg_addr_t           reg_address_i,
   input  wire [P_BYTECNT_BITS-1:0] reg_bytecnt_i,
   input  wire reg_byte_t           reg_datai_i,
   input  wire                      reg_read_i,
   input  wire                      reg_write_i,
   output reg_byte_t                reg_datao_o,
   // triggers
   input  wire                      trig_nrst_i,
   input  wire                      trig_io1_i,
   input  wire                      trig_io2_i,
   input  wire                      trig_io3_i,
   input  wire                      trig_io4_i,
   input  wire                      trig_advio_i,
   input  wire                      trig_sad_i,
   input  wire                      trig_decoded_i,
   input  wire                      trig_trace_i,
   output logic                     trigger_ext_o,
   output logic                     trigger_o,
   // target side
   inout  wire                      targetio1_io,
   inout  wire                      targetio2_io,
   inout  wire                      targetio3_io,
   inout  wire                      targetio4_io,
   input  wire                      uart_tx_i,
   output logic                     uart_rx_o,
   output logic                     power_off_o,
   output logic                     enable_avrprog_o,
   output logic                     enable_output_nrst_o,
   output logic                     output_nrst_o,
   output logic                     enable_output_pdid_o,
   output logic                     output_pdid_o,
   output logic                     enable_output_pdic_o,
   output logic                     output_pdic_o
);

   wire reg_byte_t  trigsrc;
   wire trig_mode_t trigmod;
   wire ioroute_t   ioroute;
   wire             io_highz;   // power path releases the pads

   cw_reg_bank #(
      .P_BYTECNT_BITS (P_BYTECNT_BITS)
   ) u_reg_bank (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .reg_address_i (reg_address_i),
      .reg_bytecnt_i (reg_bytecnt_i),
      .reg_datai_i   (reg_datai_i),
      .reg_read_i    (reg_read_i),
      .reg_write_i   (reg_write_i),
      .pins_i        ({targetio4_io, targetio3_io, targetio2_io, targetio1_io}),
      .reg_datao_o   (reg_datao_o),
      .trigsrc_o     (trigsrc),
      .trigmod_o     (trigmod),
      .ioroute_o     (ioroute)
   );

   trig_select u_trig_select (
      .trigsrc_i      (trigsrc),
      .trigmod_i      (trigmod),
      .trig_nrst_i    (trig_nrst_i),
      .trig_io1_i     (trig_io1_i),
      .trig_io2_i     (trig_io2_i),
      .trig_io3_i     (trig_io3_i),
      .trig_io4_i     (trig_io4_i),
      .trig_advio_i   (trig_advio_i),
      .trig_sad_i     (trig_sad_i),
      .trig_decoded_i (trig_decoded_i),
      .trig_trace_i   (trig_trace_i),
      .trigger_ext_o  (trigger_ext_o),
      .trigger_o      (trigger_o)
   );

   target_io_route u_io_route (
      .ioroute_i            (ioroute),
      .io_highz_i           (io_highz),
      .uart_tx_i            (uart_tx_i),
      .targetio1_io         (targetio1_io),
      .targetio2_io         (targetio2_io),
      .targetio3_io         (targetio3_io),
      .targetio4_io         (targetio4_io),
      .uart_rx_o            (uart_rx_o),
      .enable_avrprog_o     (enable_avrprog_o),
      .enable_output_nrst_o (enable_output_nrst_o),
      .output_nrst_o        (output_nrst_o),
      .enable_output_pdid_o (enable_output_pdid_o),
      .output_pdid_o        (output_pdid_o),
      .enable_output_pdic_o (enable_output_pdic_o),
      .output_pdic_o        (output_pdic_o)
   );

   target_power #(
      .P_PWM_BITS  (P_PWM_BITS),
      .P_PWM_ON    (P_PWM_ON),
      .P_STEP_BITS (P_STEP_BITS)
   ) u_power (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .power_off_bit_i (ioroute[IOR_EXTRA*8 + EXTRA_PWROFF]),
      .fast_start_i    (ioroute[IOR_EXTRA*8 + EXTRA_FAST]),
      .power_off_o     (power_off_o),
      .io_highz_o      (io_highz)
   );

endmodule

`default_nettype wire

//--- logic/target_power.sv
`timescale 1ns/100ps
`default_nettype none

module target_power
   import cw_route_pkg::*;
#(
   parameter int P_PWM_BITS  = 11,    // pwm period is 2**P_PWM_BITS cycles
   parameter int P_PWM_ON    = 1400,  // counts below this keep the switch off
   parameter int P_STEP_BITS = 14     // ramp length in pwm periods
) (
   input  wire  clk_usb,
   input  wire  reset,
   input  wire  power_off_bit_i,      // straight from the extra byte
   input  wire  fast_start_i,
   output logic power_off_o,
   output logic io_highz_o
);

   logic                   pwr_off_q;  // registered power-off level
   logic [P_PWM_BITS-1:0]  pwm_cnt;
   logic [P_STEP_BITS-1:0] step_cnt;
   logic                   pwm_wrap;
   logic                   step_done;
   logic                   pwm_low;
   power_state_t           state_q, state_d;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         pwr_off_q <= 1'b0;
      end else begin
         pwr_off_q <= power_off_bit_i;
      end
   end

   // free running pwm counter
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         pwm_cnt <= '0;
      end else begin
         pwm_cnt <= pwm_cnt + 1'b1;
      end
   end

   assign pwm_wrap  = (pwm_cnt == '1);
   assign pwm_low   = (pwm_cnt < P_PWM_ON);
   assign step_done = (step_cnt == '1);

   // one step per pwm period, only while ramping
   always_ff @(posedge clk_usb) begin
      if (reset || state_q != PWR_RAMP) begin
         step_cnt <= '0;
      end else if (pwm_wrap && !step_done) begin
         step_cnt <= step_cnt + 1'b1;
      end
   end

   // state moves on the same edge as pwr_off_q, so the fall is seen here directly
   always_comb begin
      state_d = state_q;
      if (power_off_bit_i) begin
         state_d = PWR_OFF;                       // off wins from any state
      end else begin
         case (state_q)
            PWR_OFF:  if (pwr_off_q) state_d = fast_start_i ? PWR_ON : PWR_RAMP;
            PWR_RAMP: if (step_done) state_d = PWR_ON;
            PWR_ON:   state_d = PWR_ON;
            default:  state_d = PWR_OFF;
         endcase
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state_q <= PWR_OFF;
      end else begin
         state_q <= state_d;
      end
   end

   assign power_off_o = (state_q == PWR_RAMP) ? pwm_low : pwr_off_q; // pwm only during ramp
   assign io_highz_o  = pwr_off_q;

   a_off_holds_off: assert property (
      @(posedge clk_usb) disable iff (reset)
      (state_q == PWR_OFF && pwr_off_q) |-> power_off_o
   );

   a_on_stays_on: assert property (
      @(posedge clk_usb) disable iff (reset)
      (state_q == PWR_ON) |-> !power_off_o
   );

endmodule

`default_nettype wire

//--- logic/target_io_route.sv
`timescale 1ns/100ps
`default_nettype none

module target_io_route
   import cw_route_pkg::*;
(
   input  wire ioroute_t ioroute_i,
   input  wire           io_highz_i,         // target unpowered so all pins stay off
   input  wire           uart_tx_i,
   inout  wire           targetio1_io,
   inout  wire           targetio2_io,
   inout  wire           targetio3_io,
   inout  wire           targetio4_io,
   output logic          uart_rx_o,
   output logic          enable_avrprog_o,
   output logic          enable_output_nrst_o,
   output logic          output_nrst_o,
   output logic          enable_output_pdid_o,
   output logic          output_pdid_o,
   output logic          enable_output_pdic_o,
   output logic          output_pdic_o
);

   wire [NUM_GPIO-1:0] pad_drv;   // driven level or z per pin
   wire [NUM_GPIO-1:0] pin_in;    // resolved pin level
   reg_byte_t          extgpio;

   // per gpio drive rule where the first match wins
   for (genvar g = 0; g < NUM_GPIO; g++) begin : g_gpio
      localparam bit IS_GPIO3 = (g == 2);  // only gpio3 has the open collector modes

      reg_byte_t cfg;

      assign cfg = ioroute_i[(IOR_GPIO1 + g)*8 +: 8];

      assign pad_drv[g] = io_highz_i                  ? 1'bz :
                          cfg[GPIO_TX]                ? uart_tx_i :
                          (IS_GPIO3 && cfg[GPIO_OC])  ? 1'b0 :
                          (IS_GPIO3 && cfg[GPIO_OCTX]) ? (uart_tx_i ? 1'bz : 1'b0) :
                          cfg[GPIO_EN]                ? cfg[GPIO_LVL] :
                          1'bz;
   end

   assign targetio1_io = pad_drv[0];
   assign targetio2_io = pad_drv[1];
   assign targetio3_io = pad_drv[2];
   assign targetio4_io = pad_drv[3];

   assign pin_in = {targetio4_io, targetio3_io, targetio2_io, targetio1_io};

   // rx follows the lowest numbered gpio with rx set and idles high
   always_comb begin
      uart_rx_o = 1'b1;
      for (int i = NUM_GPIO-1; i >= 0; i--) begin
         if (ioroute_i[(IOR_GPIO1 + i)*8 + GPIO_RX]) begin
            uart_rx_o = pin_in[i];
         end
      end
   end

   assign enable_avrprog_o = ioroute_i[IOR_EXTRA*8 + EXTRA_AVRPROG];

   // extra gpio byte holds enable and state pairs
   assign extgpio              = ioroute_i[IOR_EXTGPIO*8 +: 8];
   assign enable_output_nrst_o = extgpio[0];
   assign output_nrst_o        = extgpio[1];
   assign enable_output_pdid_o = extgpio[2];
   assign output_pdid_o        = extgpio[3];
   assign enable_output_pdic_o = extgpio[4];
   assign output_pdic_o        = extgpio[5];

   // power-off from target_power must release every pad whatever the routing says
   always_comb begin
      if (io_highz_i) begin
         a_no_drive_unpowered: assert final (pad_drv === {NUM_GPIO{1'bz}});
      end
   end

endmodule

`default_nettype wire

//--- logic/trig_select.sv
`timescale 1ns/100ps
`default_nettype none

module trig_select
   import cw_route_pkg::*;
(
   input  wire reg_byte_t  trigsrc_i,      // enables and combine mode
   input  wire trig_mode_t trigmod_i,      // which trigger module feeds trigger_o
   input  wire             trig_nrst_i,
   input  wire             trig_io1_i,
   input  wire             trig_io2_i,
   input  wire             trig_io3_i,
   input  wire             trig_io4_i,
   input  wire             trig_advio_i,
   input  wire             trig_sad_i,
   input  wire             trig_decoded_i,
   input  wire             trig_trace_i,
   output logic            trigger_ext_o,
   output logic            trigger_o
);

   logic [TRIG_LINES-1:0] trig_lines;
   logic [TRIG_LINES-1:0] trig_en;
   logic                  trig_or;
   logic                  trig_and;

   assign trig_lines = {trig_io4_i, trig_io3_i, trig_io2_i, trig_io1_i, trig_nrst_i};
   assign trig_en    = trigsrc_i[TRIGSRC_NRST +: TRIG_LINES];

   assign trig_or  = |(trig_lines & trig_en);   // any enabled line high
   assign trig_and = &(trig_lines | ~trig_en);  // masked lines count as high, so none enabled is 1

   // combine mode
   always_comb begin
      case (trigsrc_i[TRIGSRC_MODE +: 2])
         COMB_OR:   trigger_ext_o = trig_or;
         COMB_AND:  trigger_ext_o = trig_and;
         COMB_NAND: trigger_ext_o = ~trig_and;
         default:   trigger_ext_o = 1'b0;      // mode 3 unused
      endcase
   end

   // trigger module select
   always_comb begin
      case (trigmod_i)
         TRIG_EXT:     trigger_o = trigger_ext_o;
         TRIG_ADVIO:   trigger_o = trig_advio_i;
         TRIG_SAD:     trigger_o = trig_sad_i;
         TRIG_DECODED: trigger_o = trig_decoded_i;
         TRIG_TRACE:   trigger_o = trig_trace_i;
         default:      trigger_o = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- logic/cw_reg_bank.sv
`timescale 1ns/100ps
`default_nettype none

module cw_reg_bank
   import cw_route_pkg::*;
#(
   parameter int P_BYTECNT_BITS = 7
) (
   input  wire                      clk_usb,
   input  wire                      reset,
   input  wire reg_addr_t           reg_address_i,
   input  wire [P_BYTECNT_BITS-1:0] reg_bytecnt_i,   // byte within a multi-byte register
   input  wire reg_byte_t           reg_datai_i,
   input  wire                      reg_read_i,
   input  wire                      reg_write_i,
   input  wire [NUM_GPIO-1:0]       pins_i,          // resolved target pin levels
   output reg_byte_t                reg_datao_o,
   output reg_byte_t                trigsrc_o,
   output trig_mode_t               trigmod_o,
   output ioroute_t                 ioroute_o
);

   localparam reg_byte_t TRIGSRC_RST = 8'h20;                 // io4 enabled in or mode
   localparam ioroute_t  IOROUTE_RST = 64'h0000_0000_0000_0201; // gpio1 tx and gpio2 rx

   reg_byte_t           trigsrc_q;
   reg_byte_t           trigmod_q;     // bits above the code read back only
   ioroute_t            ioroute_q;
   logic [NUM_GPIO-1:0] ioread_q;      // pin levels of the last edge

   logic [2:0] byte_sel;
   logic       byte_ok;

   assign byte_sel = reg_bytecnt_i[2:0];
   assign byte_ok  = (reg_bytecnt_i < IOR_BYTES); // counts past the last byte are dropped

   // host writes
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         trigsrc_q <= TRIGSRC_RST;
         trigmod_q <= '0;
         ioroute_q <= IOROUTE_RST;
      end else if (reg_write_i) begin
         case (reg_address_i)
            CW_TRIGSRC_ADDR: trigsrc_q <= reg_datai_i;  // front panel bit 0 is only stored
            CW_TRIGMOD_ADDR: trigmod_q <= reg_datai_i;
            CW_IOROUTE_ADDR: begin
               if (byte_ok) begin
                  ioroute_q[byte_sel*8 +: 8] <= reg_datai_i;
               end
            end
            default: ;                                   // read-only or unmapped
         endcase
      end
   end

   // one sampled level per gpio on every edge
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ioread_q <= '0;
      end else begin
         ioread_q <= pins_i;
      end
   end

   // readback mux that stays at zero while the bus is idle
   always_comb begin
      reg_datao_o = '0;
      if (reg_read_i) begin
         case (reg_address_i)
            CW_TRIGSRC_ADDR: reg_datao_o = trigsrc_q;
            CW_TRIGMOD_ADDR: reg_datao_o = trigmod_q;
            CW_IOROUTE_ADDR: begin
               if (byte_ok) begin
                  reg_datao_o = ioroute_q[byte_sel*8 +: 8];
               end
            end
            CW_IOREAD_ADDR:  reg_datao_o = reg_byte_t'(ioread_q); // upper nibble zero
            default:         reg_datao_o = '0;
         endcase
      end
   end

   assign trigsrc_o = trigsrc_q;
   assign trigmod_o = trigmod_q[2:0];   // module code only
   assign ioroute_o = ioroute_q;        // glitch byte goes out but nothing uses it

   // the shared host read bus must stay quiet unless this bank is read
   a_idle_bus_zero: assert property (
      @(posedge clk_usb) disable iff (reset)
      !reg_read_i |-> (reg_datao_o == '0)
   );

endmodule

`default_nettype wire

//--- logic/cw_route_pkg.sv
`default_nettype none

package cw_route_pkg;

   // basic bus types
   typedef logic [7:0]  reg_addr_t;   // host register address
   typedef logic [7:0]  reg_byte_t;   // one data byte on the host bus
   typedef logic [63:0] ioroute_t;    // eight routing bytes, byte 0 at lsb

   localparam int IOR_BYTES = 8;      // bytes in the routing register
   localparam int NUM_GPIO  = 4;      // target gpio lines
   localparam int TRIG_LINES = 5;     // nrst + io1..io4

   // register map
   localparam reg_addr_t CW_TRIGSRC_ADDR = 8'd39;
   localparam reg_addr_t CW_TRIGMOD_ADDR = 8'd40;
   localparam reg_addr_t CW_IOROUTE_ADDR = 8'd55;
   localparam reg_addr_t CW_IOREAD_ADDR  = 8'd58;

   // byte index inside the routing register
   localparam int IOR_GPIO1   = 0;    // gpio1..gpio4 follow at 0..3
   localparam int IOR_GLITCH  = 4;    // kept for readback only
   localparam int IOR_EXTRA   = 5;
   localparam int IOR_EXTGPIO = 6;

   // bits of a gpio routing byte
   localparam int GPIO_TX   = 0;
   localparam int GPIO_RX   = 1;
   localparam int GPIO_OC   = 4;      // drive low, gpio3 only
   localparam int GPIO_OCTX = 5;      // open collector tx, gpio3 only
   localparam int GPIO_LVL  = 6;
   localparam int GPIO_EN   = 7;

   // bits of the extra byte
   localparam int EXTRA_AVRPROG = 0;
   localparam int EXTRA_PWROFF  = 1;
   localparam int EXTRA_FAST    = 2;

   // trigger source register, enables start at nrst then io1..io4
   localparam int TRIGSRC_NRST = 1;
   localparam int TRIGSRC_MODE = 6;   // 2-bit combine mode at 7:6

   localparam logic [1:0] COMB_OR   = 2'd0;
   localparam logic [1:0] COMB_AND  = 2'd1;
   localparam logic [1:0] COMB_NAND = 2'd2;

   // trigger module code
   typedef logic [2:0] trig_mode_t;
   localparam trig_mode_t TRIG_EXT     = 3'd0;
   localparam trig_mode_t TRIG_ADVIO   = 3'd1;
   localparam trig_mode_t TRIG_SAD     = 3'd2;
   localparam trig_mode_t TRIG_DECODED = 3'd3;
   localparam trig_mode_t TRIG_TRACE   = 3'd4;

   typedef enum logic [1:0] {
      PWR_OFF,
      PWR_RAMP,
      PWR_ON
   } power_state_t;

endpackage

`default_nettype wire
